// File: src/video_pkg.sv
//////////////////////////////
// Video timing constants and
// blanking struct
//////////////////////////////
package video_pkg;

    // Short test frame, pixels per line
    localparam int H_TOTAL = 64;
    // Visible part of each line
    localparam int H_ACTIVE = 48;

    // Lines per frame
    localparam int V_TOTAL = 20;
    // Visible lines
    localparam int V_ACTIVE = 16;

    // clk cycles per pixel
    // Half-pixel enable fires every CEN_DIV/2 cycles
    localparam int CEN_DIV = 4;

    // Blanking delay in pixels, matches the colour pipeline
    localparam int BLANK_DLY = 2;

    // Counter widths
    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);
    localparam int DIV_W = $clog2(CEN_DIV);

    // Blanking pair
    // High while the beam is inside the visible area
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } video_sync_t;

endpackage

// File: src/pal_pkg.sv
//////////////////////////////
// Palette sizes, CPU bus,
// colour and entry types
//////////////////////////////
package pal_pkg;

    // Byte address into the palette RAM
    localparam int PAL_AW = 8;
    // Palette depth in bytes
    localparam int PAL_SIZE = 2 ** PAL_AW;
    // Colour index, two bytes per colour
    localparam int IDX_W = PAL_AW - 1;

    // CPU side of the palette
    // Write when cs and cen are high and rnw is low
    typedef struct packed {
        logic              cs;
        logic              rnw;
        logic              cen;
        logic [PAL_AW-1:0] addr;
        logic [7:0]        dout;
    } cpu_bus_t;

    // 5-bit per gun colour, blue on top
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // Entry as stored, even address first
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pal_bytes_t;

    // Entry as a colour, top bit unused
    typedef struct packed {
        logic unused;
        rgb_t rgb;
    } pal_col_t;

    // One 16-bit palette word, seen as bytes or as a colour
    typedef union packed {
        pal_bytes_t bytes;
        pal_col_t   col;
    } pal_entry_u;

endpackage

// File: src/pxl_timing.sv
//////////////////////////////
// Pixel enables, beam counters
// and blanking
//////////////////////////////
`timescale 1ns/1ns

module pxl_timing import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        pxl_cen,
    output logic        pxl2_cen,
    output video_sync_t sync
);

    // Free running divider
    // CEN_DIV is a power of two, so it wraps by itself
    logic [DIV_W-1:0] div;

    // Beam position in pixels and lines
    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;

    // Enables are registered
    // so they stay low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            div      <= '0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
        end else begin
            div     <= div + 1'b1;
            // One pulse per pixel
            pxl_cen <= div == DIV_W'(CEN_DIV - 1);
            // Same pulse plus one half a pixel earlier
            pxl2_cen <= div == DIV_W'(CEN_DIV - 1) ||
                        div == DIV_W'(CEN_DIV / 2 - 1);
        end
    end

    // Counters and blanking move only on pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
            sync  <= '0;
        end else if (pxl_cen) begin
            // Blanking from the count of this pixel
            sync.lhbl <= h_cnt < H_W'(H_ACTIVE);
            sync.lvbl <= v_cnt < V_W'(V_ACTIVE);
            if (h_cnt == H_W'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                // End of line, step the line counter
                if (v_cnt == V_W'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/pal_ram.sv
//////////////////////////////
// Dual-port palette byte RAM
//////////////////////////////
`timescale 1ns/1ns

module pal_ram import pal_pkg::*; (
    input  logic              clk,
    input  cpu_bus_t          cpu,
    output logic [7:0]        pal_dout,
    input  logic [PAL_AW-1:0] col_addr,
    output logic [7:0]        col_data
);

    // Byte storage, inferred as block RAM
    logic [7:0] mem [PAL_SIZE];

    // CPU write strobe
    logic we;

    assign we = cpu.cs & cpu.cen & ~cpu.rnw;

    // CPU port
    // Read is unconditional, one clk latency
    // Same address read returns the old byte
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu.addr] <= cpu.dout;
        end
        pal_dout <= mem[cpu.addr];
    end

    // Colour fetch port, read only
    always_ff @(posedge clk) begin
        col_data <= mem[col_addr];
    end

endmodule

// File: src/blank_dly.sv
//////////////////////////////
// Blanking delay and black
// forcing of the colour
//////////////////////////////
`timescale 1ns/1ns

module blank_dly import video_pkg::*, pal_pkg::*; (
    input  logic        clk,
    input  logic        pxl_cen,
    input  video_sync_t sync,
    input  rgb_t        rgb_in,
    output video_sync_t sync_dly,
    output rgb_t        rgb_out
);

    // Blanking pipe, one stage per pixel
    // Starts blanked so the output is dark until it fills
    video_sync_t [BLANK_DLY-1:0] dly = '0;

    // Output registers, colour and blanking side by side
    video_sync_t sync_q = '0;
    rgb_t        rgb_q  = '0;

    // Last stage of the pipe
    video_sync_t sync_last;

    assign sync_last = dly[BLANK_DLY-1];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            dly[0] <= sync;
            for (int i = 1; i < BLANK_DLY; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    // Black outside the visible area
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            sync_q <= sync_last;
            if (sync_last.lhbl && sync_last.lvbl) begin
                rgb_q <= rgb_in;
            end else begin
                rgb_q <= '0;
            end
        end
    end

    assign sync_dly = sync_q;
    assign rgb_out  = rgb_q;

endmodule

// File: src/colmix.sv
//////////////////////////////
// Colour fetch, entry assembly
// and pixel capture
//////////////////////////////
`timescale 1ns/1ns

module colmix import video_pkg::*, pal_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic             pxl2_cen,
    input  video_sync_t      sync,
    input  cpu_bus_t         cpu,
    output logic [7:0]       pal_dout,
    input  logic [IDX_W-1:0] gfx_pxl,
    output video_sync_t      sync_dly,
    output rgb_t             rgb
);

    // Half-pixel phase, 0 fetches hi, 1 fetches lo
    logic phase;

    // Index of the pixel being fetched
    logic [IDX_W-1:0] idx_q;

    // Colour port of the RAM
    logic [PAL_AW-1:0] col_addr;
    logic [7:0]        col_data;

    // Entry under assembly
    pal_entry_u entry;

    // Colour of the previous pixel, ready for blanking
    rgb_t col_q;

    // Even address is hi, odd is lo
    assign col_addr = {idx_q, phase};

    pal_ram u_ram (
        .clk      (clk),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .col_addr (col_addr),
        .col_data (col_data)
    );

    // Phase restarts on each half-pixel enable
    // pxl2_cen covers every pxl_cen, so each pixel
    // starts on the hi byte
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b0;
        end else if (pxl2_cen) begin
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
        end
    end

    // Byte shift register
    // hi arrives two cycles after pxl_cen, lo one later,
    // so the word is complete by the next pxl_cen
    always_ff @(posedge clk) begin
        entry.bytes.hi <= entry.bytes.lo;
        entry.bytes.lo <= col_data;
    end

    // Index held for the whole fetch
    // Colour of the previous index taken in the same edge
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            idx_q <= gfx_pxl;
            col_q <= entry.col.rgb;
        end
    end

    blank_dly u_blank (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .sync     (sync),
        .rgb_in   (col_q),
        .sync_dly (sync_dly),
        .rgb_out  (rgb)
    );

endmodule

// File: src/video_mixer_top.sv
//////////////////////////////
// Palette output stage top
//////////////////////////////
`timescale 1ns/1ns

module video_mixer_top import video_pkg::*, pal_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  cpu_bus_t         cpu,
    output logic [7:0]       pal_dout,
    input  logic [IDX_W-1:0] gfx_pxl,
    output logic             pxl_cen,
    output video_sync_t      sync,
    output video_sync_t      sync_dly,
    output rgb_t             rgb
);

    // Half-pixel enable, internal to the stage
    logic pxl2_cen;

    // Test frame timing
    pxl_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .sync     (sync)
    );

    // Palette lookup and blanking
    // Two pixel periods from index to rgb
    colmix u_colmix (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .sync     (sync),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .gfx_pxl  (gfx_pxl),
        .sync_dly (sync_dly),
        .rgb      (rgb)
    );

endmodule

// File: tb/video_mixer_tb.sv
//////////////////////////////
// Testbench with palette and
// pipeline model
//////////////////////////////
`timescale 1ns/1ns

module video_mixer_tb
    import video_pkg::*, pal_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // clk cycles in one test frame
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL * CEN_DIV;
    // Fill and readback fit in one frame, decode two, display writes two
    localparam int N_PHASES = 5;
    localparam int MARGIN_CYC = 2000;
    localparam int WATCHDOG_NS = (N_PHASES * FRAME_CYC + MARGIN_CYC) * CLK_PERIOD;
    // Pregenerated pixel indices, wraps if the run is longer
    localparam int IDX_STREAM = 16384;

    // One pixel as seen at a pxl_cen edge
    typedef struct packed {
        logic [IDX_W-1:0] idx;
        video_sync_t      blank;
        int               stamp;
    } pix_sample_t;

    logic             clk;
    logic             rst;
    cpu_bus_t         cpu;
    logic [7:0]       pal_dout;
    logic [IDX_W-1:0] gfx_pxl;
    logic             pxl_cen;
    video_sync_t      sync;
    video_sync_t      sync_dly;
    rgb_t             rgb;

    int    seed;
    string test_name = "reset";

    logic [IDX_W-1:0] idx_stream [IDX_STREAM];

    // Palette model
    logic [7:0] pal_mem [PAL_SIZE];
    bit         pal_ok  [PAL_SIZE]  = '{default: 1'b0};
    // Pixel count at the last write into each colour
    int         last_wr [PAL_SIZE/2] = '{default: -1};

    // CPU read expected in the next cycle
    bit         rd_ok = 1'b0;
    logic [7:0] rd_exp;

    // Index and blanking of the last pixels, oldest first
    pix_sample_t pipe [$];
    int          pix_cnt = 0;

    // clk cycles since the last pxl_cen
    int cen_gap  = 0;
    bit cen_seen = 1'b0;

    // Frame timing counters
    bit prev_lvbl    = 1'b0;
    bit frame_seen   = 1'b0;
    int frame_pulses = 0;
    int frame_vis    = 0;
    int frames_done  = 0;

    int rd_checks  = 0;
    int pix_checks = 0;

    video_mixer_top uut (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .gfx_pxl  (gfx_pxl),
        .pxl_cen  (pxl_cen),
        .sync     (sync),
        .sync_dly (sync_dly),
        .rgb      (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_sync(input string name, input video_sync_t exp,
                              input video_sync_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    // Both bytes known and untouched since the pixel was sampled
    function automatic bit entry_known(input pix_sample_t s);
        entry_known = pal_ok[{s.idx, 1'b0}] && pal_ok[{s.idx, 1'b1}] &&
                      last_wr[s.idx] <= s.stamp;
    endfunction

    // Pulses and visible pixels between lvbl rising edges
    task automatic count_frame(input video_sync_t vs);
        if (vs.lvbl && !prev_lvbl) begin
            if (frame_seen) begin
                check_count("frame_timing pulses", H_TOTAL * V_TOTAL, frame_pulses);
                check_count("frame_timing visible", H_ACTIVE * V_ACTIVE, frame_vis);
                frames_done++;
            end
            frame_seen   = 1'b1;
            frame_pulses = 0;
            frame_vis    = 0;
        end
        frame_pulses++;
        if (vs.lhbl && vs.lvbl) begin
            frame_vis++;
        end
        prev_lvbl = vs.lvbl;
    endtask

    // Model and checks, sampled half a clock after each edge
    always @(negedge clk) begin : monitor
        pix_sample_t       s;
        pix_sample_t       cur;
        rgb_t              exp_rgb;
        logic [7:0]        hi;
        logic [7:0]        lo;
        logic [PAL_AW-1:0] a;

        // Byte addressed one clk ago, old value on a write
        if (rd_ok) begin
            check_byte({test_name, " pal_dout"}, rd_exp, pal_dout);
            rd_checks++;
        end

        cen_gap++;
        if (pxl_cen) begin
            // One pulse every CEN_DIV clk cycles
            if (cen_seen) begin
                check_count({test_name, " pxl_cen period"}, CEN_DIV, cen_gap);
            end
            cen_seen = 1'b1;
            cen_gap  = 0;

            // Output now holds the result of the oldest sample
            if (pipe.size() == 3) begin
                s = pipe.pop_front();
                check_sync({test_name, " sync_dly"}, s.blank, sync_dly);
                if (!(s.blank.lhbl && s.blank.lvbl)) begin
                    check_rgb({test_name, " blanked rgb"}, '0, rgb);
                end else if (entry_known(s)) begin
                    // Even byte is hi, odd byte is lo, top bit of hi unused
                    hi = pal_mem[{s.idx, 1'b0}];
                    lo = pal_mem[{s.idx, 1'b1}];
                    exp_rgb.blue  = hi[6:2];
                    exp_rgb.green = {hi[1:0], lo[7:5]};
                    exp_rgb.red   = lo[4:0];
                    check_rgb({test_name, " rgb"}, exp_rgb, rgb);
                    pix_checks++;
                end
            end
            cur.idx   = gfx_pxl;
            cur.blank = sync;
            cur.stamp = pix_cnt;
            pipe.push_back(cur);
            count_frame(sync);
            pix_cnt++;
        end

        // Read result due next cycle, then the write of the coming edge
        a      = cpu.addr;
        rd_ok  = pal_ok[a];
        rd_exp = pal_mem[a];
        if (cpu.cs && cpu.cen && !cpu.rnw) begin
            pal_mem[a] = cpu.dout;
            pal_ok[a]  = 1'b1;
            last_wr[a[PAL_AW-1:1]] = pix_cnt;
        end
    end

    // New index on every pxl_cen edge
    initial begin : pixel_drive
        int k;
        k = 0;
        gfx_pxl = '0;
        forever begin
            @(negedge clk);
            if (pxl_cen) begin
                @(posedge clk);
                gfx_pxl <= idx_stream[k % IDX_STREAM];
                k++;
            end
        end
    end

    task automatic cpu_write(input logic [PAL_AW-1:0] addr, input logic [7:0] data);
        cpu_bus_t b;
        b.cs   = 1'b1;
        b.rnw  = 1'b0;
        b.cen  = 1'b1;
        b.addr = addr;
        b.dout = data;
        @(posedge clk);
        cpu <= b;
    endtask

    task automatic cpu_read(input logic [PAL_AW-1:0] addr);
        cpu_bus_t b;
        b.cs   = 1'b1;
        b.rnw  = 1'b1;
        b.cen  = 1'b1;
        b.addr = addr;
        b.dout = '0;
        @(posedge clk);
        cpu <= b;
    endtask

    task automatic cpu_idle();
        cpu_bus_t b;
        b     = '0;
        b.rnw = 1'b1;
        @(posedge clk);
        cpu <= b;
    endtask

    task automatic wait_pixels(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (pxl_cen) begin
                seen++;
            end
        end
    endtask

    initial begin : main
        logic [31:0] r;
        cpu_bus_t    b;

        seed = 66666;
        rst  = 1'b1;
        cpu  = '0;
        for (int i = 0; i < IDX_STREAM; i++) begin
            r = $random(seed);
            idx_stream[i] = r[IDX_W-1:0];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Whole palette written, then read back
        test_name = "fill_readback";
        for (int a = 0; a < PAL_SIZE; a++) begin
            r = $random(seed);
            cpu_write(PAL_AW'(a), r[7:0]);
        end
        for (int a = 0; a < PAL_SIZE; a++) begin
            cpu_read(PAL_AW'(a));
        end
        cpu_idle();

        // Two frames of lookups with a quiet CPU
        test_name = "colour_decode";
        wait_pixels(2 * H_TOTAL * V_TOTAL);

        // Random CPU traffic, about one write in sixteen cycles
        test_name = "display_writes";
        repeat (2 * FRAME_CYC) begin
            r = $random(seed);
            b.cs   = r[4];
            b.cen  = r[5];
            b.rnw  = r[6] | r[7];
            b.addr = r[15:8];
            b.dout = r[23:16];
            @(posedge clk);
            cpu <= b;
        end
        cpu_idle();
        // Let the last samples leave the pipeline
        wait_pixels(4);

        if (frames_done < 3 || rd_checks < PAL_SIZE || pix_checks == 0) begin
            $display("Frame, readback or pixel checks did not run enough times");
            stop_on_error();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

endmodule

// File: video_mixer.f
src/video_pkg.sv
src/pal_pkg.sv
src/pxl_timing.sv
src/pal_ram.sv
src/blank_dly.sv
src/colmix.sv
src/video_mixer_top.sv
tb/video_mixer_tb.sv

// File: Makefile
SRCS := $(shell cat video_mixer.f)

obj_dir/Vvideo_mixer_tb: video_mixer.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns -f video_mixer.f \
		--top-module video_mixer_tb -Mdir obj_dir

.PHONY: run clean

run: obj_dir/Vvideo_mixer_tb
	@out="$$(./obj_dir/Vvideo_mixer_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
